//--- source/ascon_pkg.sv
`default_nettype none

package ascon_pkg;

    localparam int WORD_W      = 64;
    localparam int STATE_WORDS = 5;
    localparam int RATE_W      = 128;               // ascon-128a rate
    localparam int RATE_BYTES  = RATE_W / 8;
    localparam int ROUNDS_A    = 12;                // init and finalization
    localparam int ROUNDS_B    = 8;                 // between message blocks

    // linear layer rotations, x0 .. x4
    localparam int ROT_A [STATE_WORDS] = '{19, 61, 1, 10, 7};
    localparam int ROT_B [STATE_WORDS] = '{28, 39, 6, 17, 41};

    localparam logic [7:0] RC_BASE  = 8'hF0;        // constant of round 0
    localparam logic [7:0] RC_STEP  = 8'h0F;        // subtracted per round
    localparam logic [7:0] PAD_BYTE = 8'h01;

    typedef logic [WORD_W-1:0]      word_t;
    typedef word_t [STATE_WORDS-1:0] state_t;      // s[0] is x0, in the low bits
    typedef logic [RATE_W-1:0]      block_t;
    typedef word_t [1:0]            key_t;          // [0] lands in x1/x2, [1] in x2/x3
    typedef logic [4:0]             bytes_t;        // 0..16
    typedef logic [3:0]             round_t;        // 0..11

    localparam word_t DOM_SEP_WORD = {1'b1, {(WORD_W-1){1'b0}}};

    // same bit layout as state_t, so a plain cast loads the state
    typedef struct packed {
        word_t [1:0] nonce;     // x4, x3
        key_t        key;       // x2, x1
        word_t       iv;        // x0
    } init_t;

    typedef enum logic [2:0] {
        IDLE, INIT, WAIT_DATA, PERM_B, PAD_BLOCK, FINAL, TAG
    } ctrl_state_e;

    typedef enum logic [2:0] {
        HOLD, LOAD_INIT, ROUND, ABSORB, ABSORB_FINAL
    } step_e;

    typedef struct packed {
        step_e  step;
        round_t round;          // constant index, already offset for 8-round runs
        logic   key_tail;       // key into x3/x4 after this round
        logic   dom_sep;        // domain bit into x4
        logic   pad_only;       // absorb the internal 0x01 block
    } ctrl_cmd_t;

endpackage

`default_nettype wire

//--- source/ascon_round.sv
`default_nettype none

module ascon_round import ascon_pkg::*; (
    input  state_t i_state,
    input  round_t i_round,
    output state_t o_state
);

    logic [7:0] rc;
    state_t     s_rc;       // after constant addition
    state_t     s_aff;      // after first affine layer
    state_t     s_chi;      // after the nonlinear step
    state_t     s_sbox;     // after second affine layer

    function automatic word_t rotr(input word_t x, input int n);
        return (x >> n) | (x << (WORD_W - n));
    endfunction

    // constant goes on x2 only
    assign rc = RC_BASE - RC_STEP * {4'd0, i_round};

    always_comb begin
        s_rc    = i_state;
        s_rc[2] = i_state[2] ^ word_t'(rc);
    end

    // input affine layer
    always_comb begin
        s_aff    = s_rc;
        s_aff[0] = s_rc[0] ^ s_rc[4];
        s_aff[2] = s_rc[2] ^ s_rc[1];
        s_aff[4] = s_rc[4] ^ s_rc[3];
    end

    // chi across the five words, bitsliced
    always_comb begin
        for (int i = 0; i < STATE_WORDS; i++) begin
            s_chi[i] = s_aff[i]
                ^ (~s_aff[(i + 1) % STATE_WORDS] & s_aff[(i + 2) % STATE_WORDS]);
        end
    end

    // output affine layer
    always_comb begin
        s_sbox[0] = s_chi[0] ^ s_chi[4];
        s_sbox[1] = s_chi[1] ^ s_chi[0];
        s_sbox[2] = ~s_chi[2];                  // complement folded in here
        s_sbox[3] = s_chi[3] ^ s_chi[2];
        s_sbox[4] = s_chi[4];
    end

    // linear diffusion, two rotations per word
    always_comb begin
        for (int i = 0; i < STATE_WORDS; i++) begin
            o_state[i] = s_sbox[i] ^ rotr(s_sbox[i], ROT_A[i]) ^ rotr(s_sbox[i], ROT_B[i]);
        end
    end

endmodule

`default_nettype wire

//--- source/ascon_absorb.sv
`default_nettype none

module ascon_absorb import ascon_pkg::*; (
    input  state_t i_state,
    input  block_t i_data,
    input  bytes_t i_valid_bytes,
    input  logic   i_pad,           // last block, keep valid bytes and pad
    input  logic   i_pad_only,      // extra block after a full last block
    output state_t o_state,
    output block_t o_ciphertext
);

    block_t padded;
    word_t  rev_hi;     // goes into x0
    word_t  rev_lo;     // goes into x1

    // reverse the byte order inside one word
    function automatic word_t swap_bytes(input word_t w);
        word_t r;
        for (int i = 0; i < WORD_W / 8; i++) begin
            r[i*8 +: 8] = w[(WORD_W/8 - 1 - i)*8 +: 8];
        end
        return r;
    endfunction

    // byte 0 of the block sits in the top byte
    always_comb begin
        padded = '0;
        if (i_pad_only) begin
            padded[RATE_W-1 -: 8] = PAD_BYTE;
        end else if (i_pad) begin
            for (int i = 0; i < RATE_BYTES; i++) begin
                if (i < int'(i_valid_bytes))
                    padded[RATE_W-1-8*i -: 8] = i_data[RATE_W-1-8*i -: 8];
                else if (i == int'(i_valid_bytes))
                    padded[RATE_W-1-8*i -: 8] = PAD_BYTE;   // right after the data
            end
        end else begin
            padded = i_data;                    // full block, no padding
        end
    end

    assign rev_hi = swap_bytes(padded[RATE_W-1 -: WORD_W]);
    assign rev_lo = swap_bytes(padded[WORD_W-1:0]);

    always_comb begin
        o_state    = i_state;
        o_state[0] = i_state[0] ^ rev_hi;
        o_state[1] = i_state[1] ^ rev_lo;
    end

    assign o_ciphertext = {o_state[1], o_state[0]};   // rate words after the xor

endmodule

`default_nettype wire

//--- source/ascon_ctrl.sv
`default_nettype none

module ascon_ctrl import ascon_pkg::*; (
    input  logic      clk,
    input  logic      i_reset,
    input  logic      i_start,
    input  logic      i_data_valid,
    input  logic      i_last_block,
    input  bytes_t    i_valid_bytes,
    output ctrl_cmd_t o_cmd,
    output logic      o_ready_for_data,
    output logic      o_ciphertext_valid,
    output logic      o_done
);

    ctrl_state_e state_q, state_d;
    round_t      cnt_q, cnt_d;              // rounds done in this run
    logic        extra_pad_q, extra_pad_d;  // full last block seen, pad block pending
    logic        last_a;
    logic        last_b;
    logic        full_last;

    assign last_a    = (cnt_q == round_t'(ROUNDS_A - 1));
    assign last_b    = (cnt_q == round_t'(ROUNDS_B - 1));
    assign full_last = i_last_block && (i_valid_bytes == bytes_t'(RATE_BYTES));

    always_comb begin
        state_d     = state_q;
        cnt_d       = cnt_q;
        extra_pad_d = extra_pad_q;
        o_cmd       = '0;
        o_cmd.step  = HOLD;
        unique case (state_q)
            IDLE: begin
                if (i_start) begin
                    o_cmd.step  = LOAD_INIT;    // state and key load on this edge
                    cnt_d       = '0;
                    extra_pad_d = 1'b0;
                    state_d     = INIT;
                end
            end
            INIT, FINAL: begin
                o_cmd.step  = ROUND;
                o_cmd.round = cnt_q;
                cnt_d       = cnt_q + round_t'(1);
                if (last_a) begin
                    o_cmd.key_tail = 1'b1;
                    o_cmd.dom_sep  = (state_q == INIT);     // no AD, so right after init
                    cnt_d          = '0;
                    state_d        = (state_q == INIT) ? WAIT_DATA : TAG;
                end
            end
            WAIT_DATA: begin
                if (i_data_valid) begin
                    cnt_d = '0;
                    if (i_last_block && !full_last) begin
                        o_cmd.step = ABSORB_FINAL;  // padded block plus key
                        state_d    = FINAL;
                    end else begin
                        o_cmd.step  = ABSORB;
                        extra_pad_d = full_last;
                        state_d     = PERM_B;
                    end
                end
            end
            PERM_B: begin
                o_cmd.step  = ROUND;
                o_cmd.round = cnt_q + round_t'(ROUNDS_A - ROUNDS_B);   // p8 uses rc 4..11
                cnt_d       = cnt_q + round_t'(1);
                if (last_b) begin
                    cnt_d   = '0;
                    state_d = extra_pad_q ? PAD_BLOCK : WAIT_DATA;
                end
            end
            PAD_BLOCK: begin
                o_cmd.step     = ABSORB_FINAL;
                o_cmd.pad_only = 1'b1;
                extra_pad_d    = 1'b0;
                state_d        = FINAL;
            end
            TAG: state_d = IDLE;            // tag already registered
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_q     <= IDLE;
            cnt_q       <= '0;
            extra_pad_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            cnt_q       <= cnt_d;
            extra_pad_q <= extra_pad_d;
        end
    end

    assign o_ready_for_data   = (state_q == WAIT_DATA);
    assign o_ciphertext_valid = o_ready_for_data && i_data_valid;  // accept cycle
    assign o_done             = (state_q == TAG);                   // single cycle

endmodule

`default_nettype wire

//--- source/ascon_top.sv
`default_nettype none

module ascon_top import ascon_pkg::*; (
    input  logic   clk,
    input  logic   i_reset,
    input  logic   i_start,
    input  init_t  i_init,
    input  block_t i_data,
    input  logic   i_data_valid,
    input  logic   i_last_block,
    input  bytes_t i_valid_bytes,
    output logic   o_ready_for_data,
    output logic   o_ciphertext_valid,
    output block_t o_ciphertext,
    output logic   o_done,
    output key_t   o_tag
);

    ctrl_cmd_t cmd;
    state_t    state_q, state_d;
    state_t    round_out;
    state_t    absorb_out;
    key_t      key_q;
    key_t      tag_q;
    logic      final_round;

    ascon_ctrl u_ascon_ctrl (
        .clk                (clk),
        .i_reset            (i_reset),
        .i_start            (i_start),
        .i_data_valid       (i_data_valid),
        .i_last_block       (i_last_block),
        .i_valid_bytes      (i_valid_bytes),
        .o_cmd              (cmd),
        .o_ready_for_data   (o_ready_for_data),
        .o_ciphertext_valid (o_ciphertext_valid),
        .o_done             (o_done)
    );

    ascon_round u_ascon_round (
        .i_state (state_q),
        .i_round (cmd.round),
        .o_state (round_out)
    );

    ascon_absorb u_ascon_absorb (
        .i_state       (state_q),
        .i_data        (i_data),
        .i_valid_bytes (i_valid_bytes),
        .i_pad         (cmd.step == ABSORB_FINAL),
        .i_pad_only    (cmd.pad_only),
        .o_state       (absorb_out),
        .o_ciphertext  (o_ciphertext)
    );

    // next state by command
    always_comb begin
        state_d = state_q;
        unique case (cmd.step)
            LOAD_INIT: state_d = state_t'(i_init);     // iv, key, nonce into x0..x4
            ROUND: begin
                state_d = round_out;
                if (cmd.key_tail) begin
                    state_d[3] = round_out[3] ^ key_q[0];
                    state_d[4] = round_out[4] ^ key_q[1];
                end
                if (cmd.dom_sep)
                    state_d[4] = state_d[4] ^ DOM_SEP_WORD;
            end
            ABSORB: state_d = absorb_out;
            ABSORB_FINAL: begin
                state_d    = absorb_out;
                state_d[2] = absorb_out[2] ^ key_q[0];  // key right behind the rate
                state_d[3] = absorb_out[3] ^ key_q[1];
            end
            default: state_d = state_q;             // HOLD
        endcase
    end

    // last finalization round, the one with key_tail but no domain bit
    assign final_round = (cmd.step == ROUND) && cmd.key_tail && !cmd.dom_sep;

    always_ff @(posedge clk) begin
        state_q <= state_d;
        if (cmd.step == LOAD_INIT)
            key_q <= i_init.key;
    end

    // x3/x4 already carry the key xor in state_d
    always_ff @(posedge clk) begin
        if (cmd.step == LOAD_INIT)
            tag_q <= '0;
        else if (final_round)
            tag_q <= {state_d[4], state_d[3]};
    end

    assign o_tag = tag_q;

endmodule

`default_nettype wire

//--- verification/ascon_model.svh
`ifndef ASCON_MODEL_SVH
`define ASCON_MODEL_SVH

localparam int MAX_BLOCKS = 4;

typedef block_t [MAX_BLOCKS-1:0] msg_t;     // block 0 in the low bits

typedef struct packed {
    msg_t ct;                               // one ciphertext per accepted block
    key_t tag;
} result_t;

function automatic word_t model_rotr(input word_t w, input int n);
    return word_t'({w, w} >> n);            // low half of the doubled word
endfunction

// textbook round, t words computed before any update
function automatic state_t model_round(input state_t s, input int r);
    word_t x0, x1, x2, x3, x4;
    word_t t0, t1, t2, t3, t4;
    x0 = s[0];
    x1 = s[1];
    x2 = s[2] ^ word_t'(((15 - r) << 4) | r);  // round constant
    x3 = s[3];
    x4 = s[4];
    x0 ^= x4;
    x4 ^= x3;
    x2 ^= x1;
    t0 = ~x0 & x1;
    t1 = ~x1 & x2;
    t2 = ~x2 & x3;
    t3 = ~x3 & x4;
    t4 = ~x4 & x0;
    x0 ^= t1;
    x1 ^= t2;
    x2 ^= t3;
    x3 ^= t4;
    x4 ^= t0;
    x1 ^= x0;
    x0 ^= x4;
    x3 ^= x2;
    x2 = ~x2;
    s[0] = x0 ^ model_rotr(x0, 19) ^ model_rotr(x0, 28);
    s[1] = x1 ^ model_rotr(x1, 61) ^ model_rotr(x1, 39);
    s[2] = x2 ^ model_rotr(x2, 1) ^ model_rotr(x2, 6);
    s[3] = x3 ^ model_rotr(x3, 10) ^ model_rotr(x3, 17);
    s[4] = x4 ^ model_rotr(x4, 7) ^ model_rotr(x4, 41);
    return s;
endfunction

// the last `rounds` of the twelve constants
function automatic state_t model_perm(input state_t s, input int rounds);
    for (int r = 12 - rounds; r < 12; r++)
        s = model_round(s, r);
    return s;
endfunction

// keep n bytes from the top, 0x01 right after them
function automatic block_t model_pad(input block_t blk, input int n);
    block_t p;
    p = '0;
    for (int j = 0; j < n; j++)
        p[127-8*j -: 8] = blk[127-8*j -: 8];
    p[127-8*n -: 8] = 8'h01;
    return p;
endfunction

// first byte of each half lands in the low byte of its word
function automatic state_t model_absorb(input state_t s, input block_t p);
    for (int j = 0; j < 8; j++) begin
        s[0][8*j +: 8] = s[0][8*j +: 8] ^ p[127-8*j -: 8];
        s[1][8*j +: 8] = s[1][8*j +: 8] ^ p[63-8*j -: 8];
    end
    return s;
endfunction

function automatic result_t model_encrypt(input init_t ini, input msg_t msg,
                                          input int n_blocks, input int last_bytes);
    result_t res;
    state_t  s;
    key_t    k;
    res = '0;
    k = ini.key;
    s[0] = ini.iv;
    s[1] = k[0];
    s[2] = k[1];
    s[3] = ini.nonce[0];
    s[4] = ini.nonce[1];
    s = model_perm(s, 12);
    s[3] ^= k[0];
    s[4] ^= k[1];
    s[4][63] = ~s[4][63];                   // domain bit, no associated data
    for (int b = 0; b < n_blocks; b++) begin
        if (b < n_blocks - 1 || last_bytes == 16) begin
            s = model_absorb(s, msg[b]);
            res.ct[b] = {s[1], s[0]};
            s = model_perm(s, 8);
        end else begin
            s = model_absorb(s, model_pad(msg[b], last_bytes));
            res.ct[b] = {s[1], s[0]};
        end
    end
    if (last_bytes == 16)
        s = model_absorb(s, model_pad('0, 0));  // extra padding block
    s[2] ^= k[0];
    s[3] ^= k[1];
    s = model_perm(s, 12);
    res.tag = {s[4] ^ k[1], s[3] ^ k[0]};
    return res;
endfunction

`endif

//--- verification/tb_ascon.sv
`default_nettype none

module tb_ascon import ascon_pkg::*; ();

    logic        clk;
    logic        i_reset;
    logic        i_start;
    init_t       i_init;
    block_t      i_data;
    logic        i_data_valid;
    logic        i_last_block;
    bytes_t      i_valid_bytes;
    logic        o_ready_for_data;
    logic        o_ciphertext_valid;
    block_t      o_ciphertext;
    logic        o_done;
    key_t        o_tag;
    logic [31:0] lfsr;
    int          value_errors = 0;
    int          other_errors = 0;

    `include "ascon_model.svh"

    ascon_top u_ascon_top (
        .clk                (clk),
        .i_reset            (i_reset),
        .i_start            (i_start),
        .i_init             (i_init),
        .i_data             (i_data),
        .i_data_valid       (i_data_valid),
        .i_last_block       (i_last_block),
        .i_valid_bytes      (i_valid_bytes),
        .o_ready_for_data   (o_ready_for_data),
        .o_ciphertext_valid (o_ciphertext_valid),
        .o_ciphertext       (o_ciphertext),
        .o_done             (o_done),
        .o_tag              (o_tag)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);    // galois taps
    endfunction

    task automatic take_bits(input int n, output logic [127:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[126:0], lfsr[0]};            // one step per bit
        end
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("Fail %s: got %0h expected %0h", name, got, exp);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            other_errors++;
            $display("%s", what);
        end
    endtask

    task automatic check_handshake();
        check_true(!o_ciphertext_valid || (o_ready_for_data && i_data_valid),
                   "ciphertext valid high without ready and valid");
    endtask

    // poll at falling edges until ready (or done) is seen
    task automatic wait_for(input bit want_done, input int limit, inout int cycles);
        while (!(want_done ? o_done : o_ready_for_data) && cycles < limit) begin
            @(negedge clk);
            cycles++;
            check_handshake();
        end
        check_true(want_done ? o_done : o_ready_for_data,
                   want_done ? "timeout waiting for done" : "timeout waiting for ready");
    endtask

    task automatic random_init(output init_t ini);
        logic [127:0] r;
        ini.iv = 64'h8080_0c08_0000_0000;     // ascon-128a iv
        take_bits(128, r);
        ini.key = r;
        take_bits(128, r);
        ini.nonce = r;
    endtask

    task automatic run_message(input init_t ini, input msg_t msg, input int n_blocks,
                               input int last_bytes, input bit gaps, input bit restart);
        result_t      exp;
        logic [127:0] r;
        int           cycles;
        bit           last;
        exp = model_encrypt(ini, msg, n_blocks, last_bytes);
        @(negedge clk);
        i_start = 1'b1;
        i_init  = ini;
        @(negedge clk);
        i_start = 1'b0;
        cycles  = 1;
        if (gaps) begin
            i_data_valid = 1'b1;                    // offered while still in init
            #5;
            check_handshake();
            @(negedge clk);
            i_data_valid = 1'b0;
            cycles++;
        end
        wait_for(1'b0, 40, cycles);
        check_value("o_ready_for_data latency", 128'(cycles), 128'd13);
        for (int b = 0; b < n_blocks; b++) begin
            last = (b == n_blocks - 1);
            if (gaps) begin
                take_bits(2, r);
                for (int g = 0; g < int'(r[1:0]); g++) begin
                    @(negedge clk);                 // valid stays low
                    check_handshake();
                    check_true(o_ready_for_data, "ready dropped while no data came");
                end
            end
            if (restart && b == 1) begin
                i_start = 1'b1;                     // must be ignored mid message
                i_init  = init_t'(~ini);
                @(negedge clk);
                i_start = 1'b0;
                check_true(o_ready_for_data, "second start disturbed the message");
            end
            i_data        = msg[b];
            i_data_valid  = 1'b1;
            i_last_block  = last;
            i_valid_bytes = last ? bytes_t'(last_bytes) : bytes_t'(RATE_BYTES);
            #5;                                     // mid low phase, inputs settled
            check_handshake();
            check_true(o_ciphertext_valid, "block not accepted while ready was high");
            check_value("o_ciphertext", o_ciphertext, exp.ct[b]);
            @(negedge clk);
            i_data_valid = 1'b0;
            i_last_block = 1'b0;
            cycles = 1;
            if (!last) begin
                wait_for(1'b0, 40, cycles);
                check_value("o_ready_for_data latency", 128'(cycles), 128'd9);
            end
        end
        wait_for(1'b1, 40, cycles);
        check_value("o_done latency", 128'(cycles), (last_bytes == 16) ? 128'd22 : 128'd13);
        check_value("o_tag", o_tag, exp.tag);
        @(negedge clk);
        check_true(!o_done, "done stayed high longer than one cycle");
        check_value("o_tag", o_tag, exp.tag);      // holds after done
    endtask

    initial begin
        msg_t         msg;
        init_t        ini;
        logic [127:0] r;
        clk           = 1'b0;
        i_reset       = 1'b1;
        i_start       = 1'b0;
        i_init        = '0;
        i_data        = '0;
        i_data_valid  = 1'b0;
        i_last_block  = 1'b0;
        i_valid_bytes = '0;
        lfsr          = 32'd7;
        msg           = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;
        check_true(!o_ready_for_data && !o_ciphertext_valid && !o_done,
                   "outputs not idle after reset");

        random_init(ini);
        for (int b = 0; b < 3; b++) begin
            take_bits(128, r);
            msg[b] = r;
        end
        run_message(ini, msg, 3, 5, 1'b0, 1'b0);     // three blocks
        run_message(ini, msg, 3, 5, 1'b1, 1'b0);     // same, idle gaps
        run_message(ini, msg, 1, 0, 1'b0, 1'b0);     // empty message
        run_message(ini, msg, 2, 16, 1'b1, 1'b0);    // full last block
        run_message(ini, msg, 3, 9, 1'b0, 1'b1);     // start ignored
        random_init(ini);                              // new key and nonce
        run_message(ini, msg, 2, 12, 1'b0, 1'b0);

        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verification
source/ascon_pkg.sv
source/ascon_round.sv
source/ascon_absorb.sv
source/ascon_ctrl.sv
source/ascon_top.sv
verification/tb_ascon.sv

//--- run.sh
#!/bin/sh
# build and run the ascon testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ascon -f vlog.f

output=$(./obj_dir/Vtb_ascon)
echo "$output"
if echo "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
